// ==== Makefile ====
# Verilator simulation of the beam-domain dimension-reduction core

VERILATOR ?= verilator
TOP       ?= tb_dr_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: sim clean

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/beam_mac.sv ====
`timescale 1ns/10ps

module beam_mac (
    input  logic                i_clk,
    input  logic                i_reset,
    input  dr_pkg::ant_vec_t    i_ant,
    input  dr_pkg::weight_set_t i_weights,
    output dr_pkg::beam_vec_t   o_beam
);
    import dr_pkg::*;

    // complex product terms, stage 1
    logic signed [SAMPLE_W+WEIGHT_W-1:0] p_ii [N_BEAM][N_ANT];
    logic signed [SAMPLE_W+WEIGHT_W-1:0] p_qq [N_BEAM][N_ANT];
    logic signed [SAMPLE_W+WEIGHT_W-1:0] p_iq [N_BEAM][N_ANT];
    logic signed [SAMPLE_W+WEIGHT_W-1:0] p_qi [N_BEAM][N_ANT];

    beam_val_t              sum_i [N_BEAM];
    beam_val_t              sum_q [N_BEAM];
    beam_val_t [N_BEAM-1:0] beam_i_q;
    beam_val_t [N_BEAM-1:0] beam_q_q;
    logic [MAC_LAT-1:0]     vld_sr;
    logic [MAC_LAT-1:0]     sof_sr;

    //--------------------------------------------------------------------------
    // stage 1: w_ba * x_a, all four real products
    //--------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        for (int b = 0; b < N_BEAM; b++) begin
            for (int a = 0; a < N_ANT; a++) begin
                p_ii[b][a] <= $signed(i_weights.w_i[b][a]) * $signed(i_ant.i[a]);
                p_qq[b][a] <= $signed(i_weights.w_q[b][a]) * $signed(i_ant.q[a]);
                p_iq[b][a] <= $signed(i_weights.w_i[b][a]) * $signed(i_ant.q[a]);
                p_qi[b][a] <= $signed(i_weights.w_q[b][a]) * $signed(i_ant.i[a]);
            end
        end
    end

    // sum over antennas
    always_comb begin
        for (int b = 0; b < N_BEAM; b++) begin
            sum_i[b] = '0;
            sum_q[b] = '0;
            for (int a = 0; a < N_ANT; a++) begin
                sum_i[b] = sum_i[b] + p_ii[b][a] - p_qq[b][a];  // re: wi*xi - wq*xq
                sum_q[b] = sum_q[b] + p_iq[b][a] + p_qi[b][a];  // im: wi*xq + wq*xi
            end
        end
    end

    //--------------------------------------------------------------------------
    // stage 2: beam registers
    //--------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        for (int b = 0; b < N_BEAM; b++) begin
            beam_i_q[b] <= sum_i[b];
            beam_q_q[b] <= sum_q[b];
        end
    end

    // valid and sof follow the data
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            vld_sr <= '0;
            sof_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[MAC_LAT-2:0], i_ant.valid};
            sof_sr <= {sof_sr[MAC_LAT-2:0], i_ant.valid & i_ant.sof};
        end
    end

    assign o_beam.valid = vld_sr[MAC_LAT-1];
    assign o_beam.sof   = sof_sr[MAC_LAT-1];
    assign o_beam.i     = beam_i_q;
    assign o_beam.q     = beam_q_q;

endmodule

// ==== design/dr_apb_regs.sv ====
`timescale 1ns/10ps

module dr_apb_regs (
    input  logic                i_clk,
    input  logic                i_reset,
    input  dr_pkg::apb_req_t    i_apb,
    output dr_pkg::apb_rsp_t    o_apb,
    output dr_pkg::dr_cfg_t     o_cfg,
    output dr_pkg::weight_set_t o_weights
);
    import dr_pkg::*;

    dr_cfg_t     cfg_q;
    weight_set_t wgt_q;
    apb_data_t   rdata;
    logic        hit;       // address maps to a register
    logic        access;    // access phase
    logic        wr_en;

    assign access = i_apb.psel & i_apb.penable;
    assign wr_en  = access & i_apb.pwrite & hit;

    //--------------------------------------------------------------------------
    // address decode and readback
    //--------------------------------------------------------------------------
    always_comb begin
        rdata = '0;
        hit   = 1'b0;
        if (i_apb.paddr == ADDR_CTRL) begin
            hit        = 1'b1;
            rdata[1:0] = cfg_q.rbg_size;
            rdata[4]   = cfg_q.aiu_idx;
        end
        for (int b = 0; b < N_BEAM; b++) begin
            for (int a = 0; a < N_ANT; a++) begin
                // word b*N_ANT+a
                if (i_apb.paddr == apb_addr_t'(ADDR_WEIGHT_BASE + 4 * (b * N_ANT + a))) begin
                    hit         = 1'b1;
                    rdata[7:0]  = wgt_q.w_i[b][a];
                    rdata[15:8] = wgt_q.w_q[b][a];
                end
            end
        end
    end

    // no wait states
    assign o_apb.prdata  = rdata;
    assign o_apb.pready  = 1'b1;
    assign o_apb.pslverr = access & ~hit;

    //--------------------------------------------------------------------------
    // register writes
    //--------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cfg_q <= '{rbg_size: RBG4, aiu_idx: 1'b0};
            wgt_q <= '0;
        end else if (wr_en) begin
            if (i_apb.paddr == ADDR_CTRL) begin
                cfg_q.rbg_size <= rbg_size_e'(i_apb.pwdata[1:0]);
                cfg_q.aiu_idx  <= i_apb.pwdata[4];
            end
            for (int b = 0; b < N_BEAM; b++) begin
                for (int a = 0; a < N_ANT; a++) begin
                    if (i_apb.paddr == apb_addr_t'(ADDR_WEIGHT_BASE + 4 * (b * N_ANT + a))) begin
                        wgt_q.w_i[b][a] <= i_apb.pwdata[7:0];   // byte 0
                        wgt_q.w_q[b][a] <= i_apb.pwdata[15:8];  // byte 1
                    end
                end
            end
        end
    end

    assign o_cfg     = cfg_q;
    assign o_weights = wgt_q;

    // access phase must follow a setup phase
    a_apb_phase: assert property (@(posedge i_clk) disable iff (i_reset)
        i_apb.penable |-> i_apb.psel && $past(i_apb.psel));

endmodule

// ==== design/dr_core_top.sv ====
`timescale 1ns/10ps

module dr_core_top (
    input  logic              i_clk,
    input  logic              i_reset,
    input  dr_pkg::apb_req_t  i_apb,
    output dr_pkg::apb_rsp_t  o_apb,
    input  dr_pkg::ant_vec_t  i_ant,
    output dr_pkg::beam_vec_t o_beam,
    output dr_pkg::pwr_vec_t  o_pwr
);
    import dr_pkg::*;

    dr_cfg_t     cfg;
    weight_set_t weights;
    rbg_mark_t   mark;

    //--------------------------------------------------------------------------
    // control registers
    //--------------------------------------------------------------------------
    dr_apb_regs u_regs (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_apb     (i_apb),
        .o_apb     (o_apb),
        .o_cfg     (cfg),
        .o_weights (weights)
    );

    //--------------------------------------------------------------------------
    // beam path and rbG tags side by side
    //--------------------------------------------------------------------------
    beam_mac u_mac (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_ant     (i_ant),
        .i_weights (weights),
        .o_beam    (o_beam)
    );

    rbg_tracker u_tracker (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_ant   (i_ant),
        .i_cfg   (cfg),
        .o_mark  (mark)
    );

    // per-group beam power
    rbg_power_acc u_pwr (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_beam  (o_beam),
        .i_mark  (mark),
        .o_pwr   (o_pwr)
    );

endmodule

// ==== design/dr_pkg.sv ====
package dr_pkg;

    //--------------------------------------------------------------------------
    // sizes and widths
    //--------------------------------------------------------------------------
    localparam int N_ANT     = 4;
    localparam int N_BEAM    = 4;
    localparam int SAMPLE_W  = 16;
    localparam int WEIGHT_W  = 8;
    localparam int BEAM_W    = 26;   // 24b product, 4 complex terms
    localparam int PWR_SHIFT = 4;
    localparam int ACC_W     = 32;
    localparam int MAC_LAT   = 2;    // beam path depth in cycles
    localparam int SYM_RE    = 1584; // 132 PRB
    localparam int RE_SMALL  = 48;   // 4 PRB
    localparam int RE_MID    = 96;   // 8 PRB
    localparam int RE_LARGE  = 192;  // 16 PRB

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [BEAM_W-1:0]   beam_val_t;
    typedef logic [ACC_W-1:0]           pwr_t;
    typedef logic [5:0]                 rbg_idx_t;
    typedef logic [7:0]                 re_cnt_t;
    typedef logic [7:0]                 apb_addr_t;
    typedef logic [31:0]                apb_data_t;

    // register map
    localparam apb_addr_t ADDR_CTRL        = 8'h00;
    localparam apb_addr_t ADDR_WEIGHT_BASE = 8'h40; // 16 words, beam major

    typedef enum logic [1:0] {
        RBG4    = 2'd0,
        RBG8    = 2'd1,
        RBG16   = 2'd2,
        RBG_DEF = 2'd3  // same as RBG4
    } rbg_size_e;

    //--------------------------------------------------------------------------
    // bundles
    //--------------------------------------------------------------------------
    typedef struct packed {
        logic                    valid;
        logic                    sof;   // RE 0 of the symbol
        sample_t [N_ANT-1:0]     i;
        sample_t [N_ANT-1:0]     q;
    } ant_vec_t;

    typedef struct packed {
        weight_t [N_BEAM-1:0][N_ANT-1:0] w_i;
        weight_t [N_BEAM-1:0][N_ANT-1:0] w_q;
    } weight_set_t;

    typedef struct packed {
        rbg_size_e rbg_size;
        logic      aiu_idx;  // 1: short group at the end
    } dr_cfg_t;

    typedef struct packed {
        logic                    valid;
        logic                    sof;
        beam_val_t [N_BEAM-1:0]  i;
        beam_val_t [N_BEAM-1:0]  q;
    } beam_vec_t;

    typedef struct packed {
        logic     valid;
        logic     first;
        logic     last;
        rbg_idx_t rbg_idx;
    } rbg_mark_t;

    typedef struct packed {
        logic               valid;
        rbg_idx_t           rbg_idx;
        pwr_t [N_BEAM-1:0]  sum;
    } pwr_vec_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

endpackage

// ==== design/rbg_power_acc.sv ====
`timescale 1ns/10ps

module rbg_power_acc (
    input  logic              i_clk,
    input  logic              i_reset,
    input  dr_pkg::beam_vec_t i_beam,
    input  dr_pkg::rbg_mark_t i_mark,
    output dr_pkg::pwr_vec_t  o_pwr
);
    import dr_pkg::*;

    pwr_t      s1_sum [N_BEAM];     // |I|+|Q| per beam
    rbg_mark_t s1_mark;
    pwr_t      acc    [N_BEAM];
    pwr_t      acc_nxt [N_BEAM];
    pwr_t [N_BEAM-1:0] out_sum;
    rbg_idx_t  out_idx;
    logic      out_vld;

    // magnitude after scaling down
    function automatic pwr_t mag(input beam_val_t v);
        beam_val_t sh;
        sh = v >>> PWR_SHIFT;
        if (sh[BEAM_W-1])
            mag = pwr_t'(-sh);
        else
            mag = pwr_t'(sh);
    endfunction

    //--------------------------------------------------------------------------
    // stage 1: |I|+|Q|
    //--------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        for (int b = 0; b < N_BEAM; b++)
            s1_sum[b] <= mag(i_beam.i[b]) + mag(i_beam.q[b]);
    end

    always_ff @(posedge i_clk) begin
        if (i_reset)
            s1_mark <= '0;
        else
            s1_mark <= i_mark;
    end

    //--------------------------------------------------------------------------
    // stage 2: group accumulation
    //--------------------------------------------------------------------------
    always_comb begin
        for (int b = 0; b < N_BEAM; b++)
            acc_nxt[b] = s1_mark.first ? s1_sum[b] : acc[b] + s1_sum[b];  // first RE reloads
    end

    always_ff @(posedge i_clk) begin
        if (s1_mark.valid) begin
            for (int b = 0; b < N_BEAM; b++)
                acc[b] <= acc_nxt[b];
        end
        if (s1_mark.valid && s1_mark.last) begin
            for (int b = 0; b < N_BEAM; b++)
                out_sum[b] <= acc_nxt[b];
            out_idx <= s1_mark.rbg_idx;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset)
            out_vld <= 1'b0;
        else
            out_vld <= s1_mark.valid & s1_mark.last;  // one pulse per group
    end

    assign o_pwr.valid   = out_vld;
    assign o_pwr.rbg_idx = out_idx;
    assign o_pwr.sum     = out_sum;

    // beam path and tag path must stay in step
    a_align: assert property (@(posedge i_clk) disable iff (i_reset)
        i_beam.valid == i_mark.valid);

endmodule

// ==== design/rbg_tracker.sv ====
`timescale 1ns/10ps

module rbg_tracker (
    input  logic              i_clk,
    input  logic              i_reset,
    input  dr_pkg::ant_vec_t  i_ant,
    input  dr_pkg::dr_cfg_t   i_cfg,
    output dr_pkg::rbg_mark_t o_mark
);
    import dr_pkg::*;

    re_cnt_t   re_cnt;
    rbg_idx_t  rbg_cnt;
    re_cnt_t   cur_re;      // position of this RE, sof applied
    rbg_idx_t  cur_rbg;
    rbg_idx_t  g_last;      // G-1
    re_cnt_t   big_len;
    re_cnt_t   grp_len;
    logic      is_last;
    rbg_mark_t mark_new;
    rbg_mark_t mark_pipe [MAC_LAT];

    //--------------------------------------------------------------------------
    // group length
    //--------------------------------------------------------------------------
    always_comb begin
        case (i_cfg.rbg_size)
            RBG8: begin
                big_len = re_cnt_t'(RE_MID);
                g_last  = rbg_idx_t'((SYM_RE - RE_SMALL) / RE_MID);    // 16
            end
            RBG16: begin
                big_len = re_cnt_t'(RE_LARGE);
                g_last  = rbg_idx_t'((SYM_RE - RE_SMALL) / RE_LARGE);  // 8
            end
            default: begin
                big_len = re_cnt_t'(RE_SMALL);
                g_last  = rbg_idx_t'((SYM_RE - RE_SMALL) / RE_SMALL);  // 32
            end
        endcase
    end

    assign cur_re  = i_ant.sof ? '0 : re_cnt;
    assign cur_rbg = i_ant.sof ? '0 : rbg_cnt;

    // short group sits at the front or the back
    assign grp_len = (cur_rbg == (i_cfg.aiu_idx ? g_last : rbg_idx_t'(0))) ?
                     re_cnt_t'(RE_SMALL) : big_len;
    assign is_last = (cur_re == re_cnt_t'(grp_len - 1'b1));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            re_cnt  <= '0;
            rbg_cnt <= '0;
        end else if (i_ant.valid) begin
            if (is_last) begin
                re_cnt  <= '0;
                rbg_cnt <= (cur_rbg == g_last) ? '0 : cur_rbg + 1'b1;
            end else begin
                re_cnt  <= cur_re + 1'b1;
                rbg_cnt <= cur_rbg;
            end
        end
    end

    //--------------------------------------------------------------------------
    // tag pipe, lines up with beam_mac output
    //--------------------------------------------------------------------------
    assign mark_new.valid   = i_ant.valid;
    assign mark_new.first   = i_ant.valid & (cur_re == '0);
    assign mark_new.last    = i_ant.valid & is_last;
    assign mark_new.rbg_idx = cur_rbg;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int k = 0; k < MAC_LAT; k++)
                mark_pipe[k] <= '0;
        end else begin
            mark_pipe[0] <= mark_new;
            for (int k = 1; k < MAC_LAT; k++)
                mark_pipe[k] <= mark_pipe[k-1];
        end
    end

    assign o_mark = mark_pipe[MAC_LAT-1];

    a_rbg_range: assert property (@(posedge i_clk) disable iff (i_reset)
        o_mark.valid |-> o_mark.rbg_idx <= g_last);
    a_sof_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        i_ant.sof |-> i_ant.valid);

endmodule

// ==== list.f ====
design/dr_pkg.sv
design/dr_apb_regs.sv
design/beam_mac.sv
design/rbg_tracker.sv
design/rbg_power_acc.sv
design/dr_core_top.sv
tb/tb_dr_core.sv

// ==== tb/tb_dr_core.sv ====
`timescale 1ns/10ps

module tb_dr_core;
    import dr_pkg::*;

    localparam int N_ROWS  = 6;
    localparam int APB_CYC = 120;  // ~35 transfers of 3 cycles per row
    localparam int SLACK   = 50;

    typedef struct {
        string     name;
        rbg_size_e size;
        logic      aiu;
        int        wsel;    // 0 unit, 2 extremes, else random
        int        n_re;
        int        sof_at;  // 0: no second sof
        int        n_pwr;   // power results expected in the row
    } row_t;

    row_t rows [N_ROWS] = '{
        '{"rbg4_aiu0",   RBG4,    1'b0, 0, 1584,   0, 33},
        '{"rbg8_aiu1",   RBG8,    1'b1, 1, 1584,   0, 17},
        '{"rbg16_aiu0",  RBG16,   1'b0, 2, 1584,   0,  9},
        '{"rbg16_aiu1",  RBG16,   1'b1, 3, 1584,   0,  9},
        '{"rbgdef_aiu1", RBG_DEF, 1'b1, 1, 1584,   0, 33},
        '{"early_sof",   RBG8,    1'b0, 3,  400, 150,  5}
    };

    logic      i_clk = 1'b0;
    logic      i_reset;
    apb_req_t  apb;
    apb_rsp_t  apb_rsp;
    ant_vec_t  ant;
    beam_vec_t beam;
    pwr_vec_t  pwr;

    integer    seed;
    string     cur_test;
    int        n_checks;
    int        n_mism;
    int        n_other;
    int        pwr_cnt;
    int        cycle_cnt;
    int        cycle_limit;

    // model state
    weight_t   wgt_i [N_BEAM][N_ANT];
    weight_t   wgt_q [N_BEAM][N_ANT];
    sample_t   xi [N_ANT];
    sample_t   xq [N_ANT];
    rbg_size_e cfg_size;
    logic      cfg_aiu;
    int        m_re;
    int        m_grp;
    longint    m_acc [N_BEAM];
    beam_vec_t exp_beam_q [$];
    pwr_vec_t  exp_pwr_q [$];
    beam_vec_t exp_b;
    pwr_vec_t  exp_p;

    dr_core_top uut (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_apb   (apb),
        .o_apb   (apb_rsp),
        .i_ant   (ant),
        .o_beam  (beam),
        .o_pwr   (pwr)
    );

    always #20 i_clk = ~i_clk;

    //--------------------------------------------------------------------------
    // compare and bookkeeping
    //--------------------------------------------------------------------------
    task automatic check_val(input string what, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        n_checks++;
        if (exp_v !== act_v) begin
            n_mism++;
            $display("error %s: %s expected %0h actual %0h", cur_test, what, exp_v, act_v);
        end
    endtask

    function automatic int groups_per_sym(input rbg_size_e s);
        case (s)
            RBG8:    return 17;
            RBG16:   return 9;
            default: return 33;
        endcase
    endfunction

    function automatic int group_len(input rbg_size_e s, input logic aiu, input int g);
        int big;
        int short_g;
        case (s)
            RBG8:    big = 96;
            RBG16:   big = 192;
            default: big = 48;
        endcase
        short_g = aiu ? groups_per_sym(s) - 1 : 0;  // 48-RE group placement
        return (g == short_g) ? 48 : big;
    endfunction

    function automatic apb_data_t ctrl_word();
        return {27'd0, cfg_aiu, 2'b00, cfg_size};
    endfunction

    function automatic apb_addr_t weight_addr(input int b, input int a);
        return apb_addr_t'(ADDR_WEIGHT_BASE + 4 * (b * N_ANT + a));
    endfunction

    //--------------------------------------------------------------------------
    // APB transfers, setup then access
    //--------------------------------------------------------------------------
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(posedge i_clk);
        apb.psel    <= 1'b1;
        apb.penable <= 1'b0;
        apb.pwrite  <= 1'b1;
        apb.paddr   <= addr;
        apb.pwdata  <= data;
        @(posedge i_clk);
        apb.penable <= 1'b1;
        @(posedge i_clk);
        apb.psel    <= 1'b0;
        apb.penable <= 1'b0;
        apb.pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge i_clk);
        apb.psel    <= 1'b1;
        apb.penable <= 1'b0;
        apb.pwrite  <= 1'b0;
        apb.paddr   <= addr;
        @(posedge i_clk);
        apb.penable <= 1'b1;
        @(posedge i_clk);
        data = apb_rsp.prdata;  // end of access phase
        err  = apb_rsp.pslverr;
        check_val("pready", 1, apb_rsp.pready);
        apb.psel    <= 1'b0;
        apb.penable <= 1'b0;
    endtask

    task automatic write_config(input int wsel);
        apb_write(ADDR_CTRL, ctrl_word());
        for (int b = 0; b < N_BEAM; b++) begin
            for (int a = 0; a < N_ANT; a++) begin
                case (wsel)
                    0: begin
                        wgt_i[b][a] = (b == a) ? weight_t'(1) : weight_t'(0);
                        wgt_q[b][a] = weight_t'(0);
                    end
                    2: begin
                        wgt_i[b][a] = ((b + a) % 2 == 1) ? weight_t'(-128) : weight_t'(127);
                        wgt_q[b][a] = (b == a) ? weight_t'(-128) : weight_t'(16 * b - 8 * a);
                    end
                    default: begin
                        wgt_i[b][a] = weight_t'($random(seed));
                        wgt_q[b][a] = weight_t'($random(seed));
                    end
                endcase
                apb_write(weight_addr(b, a), {16'd0, wgt_q[b][a], wgt_i[b][a]});
            end
        end
    endtask

    task automatic verify_config();
        apb_data_t rd;
        logic      err;
        apb_read(ADDR_CTRL, rd, err);
        check_val("ctrl readback", ctrl_word(), rd);
        check_val("ctrl pslverr", 0, err);
        for (int b = 0; b < N_BEAM; b++) begin
            for (int a = 0; a < N_ANT; a++) begin
                apb_read(weight_addr(b, a), rd, err);
                check_val($sformatf("weight b%0d a%0d", b, a),
                          {16'd0, wgt_q[b][a], wgt_i[b][a]}, rd);
            end
        end
        apb_read(8'h24, rd, err);  // hole between CTRL and weights
        check_val("unmapped pslverr", 1, err);
        apb_read(8'h80, rd, err);  // past the last weight word
        check_val("unmapped pslverr", 1, err);
    endtask

    //--------------------------------------------------------------------------
    // reference model, one RE
    //--------------------------------------------------------------------------
    task automatic model_re(input logic sof);
        longint    si;
        longint    sq;
        longint    t_i;
        longint    t_q;
        longint    pw [N_BEAM];
        beam_vec_t eb;
        pwr_vec_t  ep;
        eb       = '0;
        eb.valid = 1'b1;
        eb.sof   = sof;
        for (int b = 0; b < N_BEAM; b++) begin
            si = 0;
            sq = 0;
            for (int a = 0; a < N_ANT; a++) begin
                si += longint'(wgt_i[b][a]) * longint'(xi[a]) -
                      longint'(wgt_q[b][a]) * longint'(xq[a]);
                sq += longint'(wgt_i[b][a]) * longint'(xq[a]) +
                      longint'(wgt_q[b][a]) * longint'(xi[a]);
            end
            eb.i[b] = beam_val_t'(si);  // wraps to beam width
            eb.q[b] = beam_val_t'(sq);
            t_i = longint'($signed(eb.i[b])) >>> PWR_SHIFT;
            t_q = longint'($signed(eb.q[b])) >>> PWR_SHIFT;
            if (t_i < 0)
                t_i = -t_i;
            if (t_q < 0)
                t_q = -t_q;
            pw[b] = t_i + t_q;
        end
        exp_beam_q.push_back(eb);

        if (sof) begin  // restart, partial group is lost
            m_re  = 0;
            m_grp = 0;
        end
        for (int b = 0; b < N_BEAM; b++)
            m_acc[b] = (m_re == 0) ? pw[b] : m_acc[b] + pw[b];
        if (m_re == group_len(cfg_size, cfg_aiu, m_grp) - 1) begin
            ep         = '0;
            ep.valid   = 1'b1;
            ep.rbg_idx = rbg_idx_t'(m_grp);
            for (int b = 0; b < N_BEAM; b++)
                ep.sum[b] = pwr_t'(m_acc[b]);
            exp_pwr_q.push_back(ep);
            m_re  = 0;
            m_grp = (m_grp == groups_per_sym(cfg_size) - 1) ? 0 : m_grp + 1;
        end else begin
            m_re++;
        end
    endtask

    task automatic run_row(input row_t r);
        logic is_sof;
        cur_test = r.name;
        cfg_size = r.size;
        cfg_aiu  = r.aiu;
        write_config(r.wsel);
        verify_config();
        pwr_cnt = 0;
        for (int k = 0; k < r.n_re; k++) begin
            @(posedge i_clk);
            is_sof = (k == 0) || (r.sof_at != 0 && k == r.sof_at);
            for (int a = 0; a < N_ANT; a++) begin
                xi[a] = sample_t'($random(seed));
                xq[a] = sample_t'($random(seed));
                ant.i[a] <= xi[a];
                ant.q[a] <= xq[a];
            end
            ant.valid <= 1'b1;
            ant.sof   <= is_sof;
            model_re(is_sof);
        end
        @(posedge i_clk);
        ant.valid <= 1'b0;
        ant.sof   <= 1'b0;
        while (exp_beam_q.size() != 0 || exp_pwr_q.size() != 0)
            @(posedge i_clk);
        repeat (4) @(posedge i_clk);  // catch a stray power result
        check_val("power result count", r.n_pwr, pwr_cnt);
    endtask

    //--------------------------------------------------------------------------
    // output monitor
    //--------------------------------------------------------------------------
    always @(posedge i_clk) begin
        if (!i_reset && beam.valid) begin
            if (exp_beam_q.size() == 0) begin
                n_other++;
                $display("unexpected beam output in test %s", cur_test);
            end else begin
                exp_b = exp_beam_q.pop_front();
                check_val("beam sof", exp_b.sof, beam.sof);
                for (int b = 0; b < N_BEAM; b++) begin
                    check_val($sformatf("beam %0d I", b), exp_b.i[b], beam.i[b]);
                    check_val($sformatf("beam %0d Q", b), exp_b.q[b], beam.q[b]);
                end
            end
        end
        if (!i_reset && pwr.valid) begin
            pwr_cnt++;
            if (exp_pwr_q.size() == 0) begin
                n_other++;
                $display("unexpected power result in test %s", cur_test);
            end else begin
                exp_p = exp_pwr_q.pop_front();
                check_val("rbg_idx", exp_p.rbg_idx, pwr.rbg_idx);
                for (int b = 0; b < N_BEAM; b++)
                    check_val($sformatf("power beam %0d", b), exp_p.sum[b], pwr.sum[b]);
            end
        end
    end

    // run limit
    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    //--------------------------------------------------------------------------
    // main sequence
    //--------------------------------------------------------------------------
    initial begin
        seed      = 82;
        n_checks  = 0;
        n_mism    = 0;
        n_other   = 0;
        pwr_cnt   = 0;
        cycle_cnt = 0;
        m_re      = 0;
        m_grp     = 0;
        i_reset   = 1'b1;
        apb       = '0;
        ant       = '0;
        cur_test  = "reset";

        cycle_limit = APB_CYC + SLACK;  // reset and readback of zeros
        for (int r = 0; r < N_ROWS; r++)
            cycle_limit += rows[r].n_re + APB_CYC + SLACK;

        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;

        // everything reads zero out of reset
        cfg_size = RBG4;
        cfg_aiu  = 1'b0;
        for (int b = 0; b < N_BEAM; b++) begin
            for (int a = 0; a < N_ANT; a++) begin
                wgt_i[b][a] = '0;
                wgt_q[b][a] = '0;
            end
        end
        verify_config();

        for (int r = 0; r < N_ROWS; r++)
            run_row(rows[r]);

        $display("checks %0d, value errors %0d, other errors %0d", n_checks, n_mism, n_other);
        if (n_mism == 0 && n_other == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule
